// File: rtl/simd_defs.svh
/*
 * SIMD unit parameters
 * Vector length, lane width and the pipeline latencies
 */
`ifndef SIMD_DEFS_SVH
`define SIMD_DEFS_SVH

`define SIMD_VLEN  128                      // Vector register width
`define SIMD_ELEN  64                       // Lane width
`define SIMD_LANES (`SIMD_VLEN / `SIMD_ELEN)

// Longest pipe, a reduction at SEW 8 or 16
`define SIMD_MAX_LAT   5

`define SIMD_MUL_LAT   2                    // Multiply at SEW 8..32
`define SIMD_MUL64_LAT 3                    // Multiply at SEW 64

`endif

// File: rtl/simd_pkg.sv
/*
 * SIMD unit types
 * Issue and write-back records, opcodes and the element helpers
 */
`include "simd_defs.svh"

package simd_pkg;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    typedef enum logic [3:0] {
        VADD, VSUB, VAND, VOR, VXOR, VMUL,
        VREDSUM, VREDAND, VREDOR, VREDXOR,
        VMERGE, VMV_X_S, VEXT
    } simd_op_e;

    typedef logic [`SIMD_ELEN-1:0] lane_word_t;
    typedef logic [2:0]            simd_lat_t;

    typedef struct packed {
        logic                  valid;
        simd_op_e              op;
        sew_e                  sew;
        logic                  use_mask;
        logic                  is_opvx;
        logic                  is_opvi;
        logic [4:0]            imm;          // Signed immediate
        logic [63:0]           data_rs1;
        logic [`SIMD_VLEN-1:0] data_vs1;
        logic [`SIMD_VLEN-1:0] data_vs2;
        logic [`SIMD_VLEN-1:0] data_old_vd;
        logic [`SIMD_VLEN-1:0] data_vm;
        logic [4:0]            vd;
        logic [4:0]            rd;
    } simd_instr_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [63:0] result;
    } simd_swb_t;

    typedef struct packed {
        logic                  valid;
        logic [4:0]            vd;
        logic [`SIMD_VLEN-1:0] vresult;
    } simd_vwb_t;

    function automatic logic is_reduction(simd_op_e op);
        return (op == VREDSUM) || (op == VREDAND) || (op == VREDOR) || (op == VREDXOR);
    endfunction

    function automatic simd_lat_t op_latency(simd_op_e op, sew_e sew);
        if (op == VMUL) begin
            return (sew == SEW_64) ? simd_lat_t'(`SIMD_MUL64_LAT) : simd_lat_t'(`SIMD_MUL_LAT);
        end
        if (is_reduction(op)) begin
            case (sew)
                SEW_64:  return simd_lat_t'(`SIMD_MAX_LAT - 2);
                SEW_32:  return simd_lat_t'(`SIMD_MAX_LAT - 1);
                default: return simd_lat_t'(`SIMD_MAX_LAT);   // SEW 16 padded
            endcase
        end
        return simd_lat_t'(1);
    endfunction

    // Element-wise op on one lane word, no carry across SEW elements
    function automatic lane_word_t lane_op(simd_op_e op, sew_e sew, lane_word_t a, lane_word_t b);
        lane_word_t  mask;
        lane_word_t  ea;
        lane_word_t  eb;
        lane_word_t  er;
        int unsigned ew;
        ew = 8 << sew;
        mask = (sew == SEW_64) ? '1 : ((64'd1 << ew) - 64'd1);
        lane_op = '0;
        for (int i = 0; i < 8; i++) begin
            if (i * ew < `SIMD_ELEN) begin
                ea = (a >> (i * ew)) & mask;
                eb = (b >> (i * ew)) & mask;
                case (op)
                    VADD, VREDSUM: er = ea + eb;
                    VSUB:          er = ea - eb;     // vs2 - vs1
                    VAND, VREDAND: er = ea & eb;
                    VOR, VREDOR:   er = ea | eb;
                    VXOR, VREDXOR: er = ea ^ eb;
                    VMUL:          er = ea * eb;     // Low half only
                    VMERGE:        er = eb;
                    default:       er = '0;
                endcase
                lane_op = lane_op | ((er & mask) << (i * ew));
            end
        end
    endfunction

endpackage

// File: rtl/simd_operand_prep.sv
/*
 * Operand preparation
 * Replicates rs1 or the immediate for .vx/.vi forms and splits
 * both sources into 64-bit lanes
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_operand_prep (
    input  simd_pkg::simd_instr_t                    instruction_i,
    output simd_pkg::lane_word_t [`SIMD_LANES-1:0]   vs1_lanes_o,
    output simd_pkg::lane_word_t [`SIMD_LANES-1:0]   vs2_lanes_o
);

    import simd_pkg::*;

    int unsigned           ew;
    lane_word_t            emask;
    lane_word_t            scalar;
    logic [`SIMD_VLEN-1:0] replicated;
    logic [`SIMD_VLEN-1:0] vs1_src;

    always_comb begin
        ew = 8 << instruction_i.sew;
        emask = (instruction_i.sew == SEW_64) ? '1 : ((64'd1 << ew) - 64'd1);
        scalar = instruction_i.is_opvx ? instruction_i.data_rs1 :
                 {{59{instruction_i.imm[4]}}, instruction_i.imm};
        replicated = '0;
        for (int i = 0; i < `SIMD_VLEN / 8; i++) begin
            if (i * ew < `SIMD_VLEN) begin
                replicated = replicated | (`SIMD_VLEN'(scalar & emask) << (i * ew));
            end
        end
        vs1_src = (instruction_i.is_opvx || instruction_i.is_opvi) ? replicated :
                  instruction_i.data_vs1;
    end

    always_comb begin
        for (int l = 0; l < `SIMD_LANES; l++) begin
            vs1_lanes_o[l] = vs1_src[l*`SIMD_ELEN +: `SIMD_ELEN];
            vs2_lanes_o[l] = instruction_i.data_vs2[l*`SIMD_ELEN +: `SIMD_ELEN];
        end
    end

endmodule

// File: rtl/simd_lane_fu.sv
/*
 * SIMD lane functional unit
 * One 64-bit lane with the ALU and multiplier, results held in one
 * shift pipe per latency
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_lane_fu (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  simd_pkg::simd_op_e    op_i,
    input  simd_pkg::sew_e        sew_i,
    input  logic                  valid_i,
    input  simd_pkg::lane_word_t  vs1_i,
    input  simd_pkg::lane_word_t  vs2_i,
    input  simd_pkg::simd_lat_t   done_lat_i,
    output simd_pkg::lane_word_t  vd_o
);

    import simd_pkg::*;

    lane_word_t result;
    simd_lat_t  lat;
    logic       wr_en;
    lane_word_t tail [1:`SIMD_MUL64_LAT];

    assign result = lane_op(op_i, sew_i, vs2_i, vs1_i);
    assign lat    = op_latency(op_i, sew_i);
    assign wr_en  = valid_i && !is_reduction(op_i);   // Reductions go to the tree

    for (genvar g = 1; g <= `SIMD_MUL64_LAT; g++) begin : g_pipe
        lane_word_t res_q [0:g-1];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int s = 0; s < g; s++) begin
                    res_q[s] <= '0;
                end
            end else begin
                res_q[0] <= (wr_en && (lat == simd_lat_t'(g))) ? result : '0;
                for (int s = 1; s < g; s++) begin
                    res_q[s] <= res_q[s-1];
                end
            end
        end

        assign tail[g] = res_q[g-1];
    end

    // Pipe named by the completing instruction
    always_comb begin
        vd_o = '0;
        for (int l = 1; l <= `SIMD_MUL64_LAT; l++) begin
            if (done_lat_i == simd_lat_t'(l)) begin
                vd_o = tail[l];
            end
        end
    end

endmodule

// File: rtl/simd_latency_tracker.sv
/*
 * Latency tracker
 * One shift pipe of instruction records per latency, reports the
 * record that reaches the end of its pipe
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_latency_tracker (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  simd_pkg::simd_instr_t  instruction_i,
    output simd_pkg::simd_instr_t  done_instr_o,
    output simd_pkg::simd_lat_t    done_lat_o
);

    import simd_pkg::*;

    simd_lat_t   issue_lat;
    simd_instr_t tail [1:`SIMD_MAX_LAT];

    assign issue_lat = op_latency(instruction_i.op, instruction_i.sew);

    for (genvar g = 1; g <= `SIMD_MAX_LAT; g++) begin : g_pipe
        simd_instr_t pipe_q [0:g-1];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int s = 0; s < g; s++) begin
                    pipe_q[s] <= '0;
                end
            end else begin
                pipe_q[0] <= (instruction_i.valid && (issue_lat == simd_lat_t'(g))) ?
                             instruction_i : '0;
                for (int s = 1; s < g; s++) begin
                    pipe_q[s] <= pipe_q[s-1];   // One slot per cycle
                end
            end
        end

        assign tail[g] = pipe_q[g-1];
    end

    // Longest pipe first so the shortest one wins
    always_comb begin
        done_instr_o = '0;
        done_lat_o   = '0;
        for (int l = `SIMD_MAX_LAT; l >= 1; l--) begin
            if (tail[l].valid) begin
                done_instr_o = tail[l];
                done_lat_o   = simd_lat_t'(l);
            end
        end
    end

endmodule

// File: rtl/simd_red_tree.sv
/*
 * Reduction tree
 * Halves the vs2 elements once per registered level, padded to the
 * reduction latency, and folds in vs1 element 0 at the tap
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_red_tree (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  simd_pkg::simd_op_e     op_i,
    input  simd_pkg::sew_e         sew_i,
    input  logic                   valid_i,
    input  logic [`SIMD_VLEN-1:0]  vs1_i,
    input  logic [`SIMD_VLEN-1:0]  vs2_i,
    output simd_pkg::lane_word_t   red_o
);

    import simd_pkg::*;

    typedef struct packed {
        logic       valid;
        simd_op_e   op;
        sew_e       sew;
        simd_lat_t  lat;
        lane_word_t acc;     // vs1 element 0
        lane_word_t data;
    } red_stage_t;

    red_stage_t  st_d [1:`SIMD_MAX_LAT];
    red_stage_t  st_q [1:`SIMD_MAX_LAT];
    int unsigned nw;
    lane_word_t  nmask;

    always_comb begin
        st_d[1].valid = valid_i && is_reduction(op_i);
        st_d[1].op    = op_i;
        st_d[1].sew   = sew_i;
        st_d[1].lat   = op_latency(op_i, sew_i);
        st_d[1].acc   = vs1_i[`SIMD_ELEN-1:0];
        st_d[1].data  = lane_op(op_i, sew_i, vs2_i[`SIMD_ELEN-1:0], vs2_i[`SIMD_VLEN-1:`SIMD_ELEN]);
        nw = 0;
        nmask = '0;
        for (int k = 2; k <= `SIMD_MAX_LAT; k++) begin
            st_d[k] = st_q[k-1];
            nw = `SIMD_VLEN >> k;
            if ((8 << st_q[k-1].sew) <= nw) begin     // Otherwise a padding stage
                nmask = (64'd1 << nw) - 64'd1;
                st_d[k].data = lane_op(st_q[k-1].op, st_q[k-1].sew,
                                       st_q[k-1].data & nmask,
                                       (st_q[k-1].data >> nw) & nmask);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int k = 1; k <= `SIMD_MAX_LAT; k++) begin
                st_q[k] <= '0;
            end
        end else begin
            for (int k = 1; k <= `SIMD_MAX_LAT; k++) begin
                st_q[k] <= st_d[k];
            end
        end
    end

    // Tap the level whose index matches the entry's latency
    always_comb begin
        red_o = '0;
        for (int k = 1; k <= `SIMD_MAX_LAT; k++) begin
            if (st_q[k].valid && (st_q[k].lat == simd_lat_t'(k))) begin
                red_o = lane_op(st_q[k].op, st_q[k].sew, st_q[k].data, st_q[k].acc);
            end
        end
    end

endmodule

// File: rtl/simd_result_merge.sv
/*
 * Result merge
 * Selects the completing result, applies the mask, computes the
 * scalar extracts and builds the write-back records
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_result_merge (
    input  simd_pkg::simd_instr_t                   done_instr_i,
    input  simd_pkg::lane_word_t [`SIMD_LANES-1:0]  vd_lanes_i,
    input  simd_pkg::lane_word_t                    red_i,
    output simd_pkg::simd_swb_t                     swb_o,
    output simd_pkg::simd_vwb_t                     vwb_o
);

    import simd_pkg::*;

    int unsigned           ew;
    lane_word_t            emask;
    lane_word_t            elem0_sext;
    lane_word_t            ext_elem;
    logic [`SIMD_VLEN-1:0] shifted;
    logic [`SIMD_VLEN-1:0] active;
    logic [`SIMD_VLEN-1:0] base;
    logic [`SIMD_VLEN-1:0] vresult;
    logic                  is_scalar;

    // Scalar extracts
    always_comb begin
        ew = 8 << done_instr_i.sew;
        emask = (done_instr_i.sew == SEW_64) ? '1 : ((64'd1 << ew) - 64'd1);
        elem0_sext = done_instr_i.data_vs2[`SIMD_ELEN-1:0] & emask;
        if (done_instr_i.data_vs2[ew-1]) begin
            elem0_sext = elem0_sext | ~emask;
        end
        shifted  = done_instr_i.data_vs2 >> (done_instr_i.data_rs1[3:0] * ew);
        ext_elem = (done_instr_i.data_rs1 < 64'(`SIMD_VLEN / ew)) ?
                   (shifted[`SIMD_ELEN-1:0] & emask) : '0;   // 0 when out of range
    end

    // Masked vector result
    always_comb begin
        active = '0;
        for (int i = 0; i < `SIMD_VLEN / 8; i++) begin
            if ((i * ew < `SIMD_VLEN) && (done_instr_i.data_vm[i] || !done_instr_i.use_mask)) begin
                active = active | (`SIMD_VLEN'(emask) << (i * ew));
            end
        end
        base = (done_instr_i.op == VMERGE) ? done_instr_i.data_vs2 : done_instr_i.data_old_vd;
        if (is_reduction(done_instr_i.op)) begin
            vresult = done_instr_i.data_old_vd;
            vresult[`SIMD_ELEN-1:0] = (done_instr_i.data_old_vd[`SIMD_ELEN-1:0] & ~emask) |
                                      (red_i & emask);
        end else begin
            vresult = (vd_lanes_i & active) | (base & ~active);
        end
    end

    assign is_scalar = (done_instr_i.op == VMV_X_S) || (done_instr_i.op == VEXT);

    assign swb_o.valid   = done_instr_i.valid && is_scalar;
    assign swb_o.rd      = done_instr_i.rd;
    assign swb_o.result  = (done_instr_i.op == VEXT) ? ext_elem : elem0_sext;

    assign vwb_o.valid   = done_instr_i.valid && !is_scalar;
    assign vwb_o.vd      = done_instr_i.vd;
    assign vwb_o.vresult = vresult;

endmodule

// File: rtl/simd_unit.sv
/*
 * Vector SIMD execution unit
 * VLEN 128 over two 64-bit lanes, several instructions in flight
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  simd_pkg::simd_instr_t  instruction_i,
    output simd_pkg::simd_swb_t    swb_o,
    output simd_pkg::simd_vwb_t    vwb_o
);

    import simd_pkg::*;

    lane_word_t [`SIMD_LANES-1:0] vs1_lanes;
    lane_word_t [`SIMD_LANES-1:0] vs2_lanes;
    lane_word_t [`SIMD_LANES-1:0] vd_lanes;
    lane_word_t                   red_data;
    simd_instr_t                  done_instr;
    simd_lat_t                    done_lat;

    simd_operand_prep operand_prep_i (
        .instruction_i (instruction_i),
        .vs1_lanes_o   (vs1_lanes),
        .vs2_lanes_o   (vs2_lanes)
    );

    for (genvar l = 0; l < `SIMD_LANES; l++) begin : g_lane
        simd_lane_fu lane_fu_i (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .op_i       (instruction_i.op),
            .sew_i      (instruction_i.sew),
            .valid_i    (instruction_i.valid),
            .vs1_i      (vs1_lanes[l]),
            .vs2_i      (vs2_lanes[l]),
            .done_lat_i (done_lat),
            .vd_o       (vd_lanes[l])
        );
    end

    simd_latency_tracker latency_tracker_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (instruction_i),
        .done_instr_o  (done_instr),
        .done_lat_o    (done_lat)
    );

    simd_red_tree red_tree_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .op_i    (instruction_i.op),
        .sew_i   (instruction_i.sew),
        .valid_i (instruction_i.valid),
        .vs1_i   (instruction_i.data_vs1),
        .vs2_i   (instruction_i.data_vs2),
        .red_o   (red_data)
    );

    simd_result_merge result_merge_i (
        .done_instr_i (done_instr),
        .vd_lanes_i   (vd_lanes),
        .red_i        (red_data),
        .swb_o        (swb_o),
        .vwb_o        (vwb_o)
    );

endmodule

// File: testbench/simd_unit_properties.sv
/*
 * Latency tracker assertions
 * Bound into the tracker, checks completion order and timing
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module simd_unit_properties (
    input logic                    clk_i,
    input logic                    rstn_i,
    input simd_pkg::simd_instr_t   instruction_i,
    input simd_pkg::simd_instr_t   done_instr_i,
    input simd_pkg::simd_lat_t     done_lat_i,
    input logic [`SIMD_MAX_LAT:1]  tail_valid_i
);

    import simd_pkg::*;

    logic [`SIMD_MAX_LAT:1] issued;

    always_comb begin
        for (int l = 1; l <= `SIMD_MAX_LAT; l++) begin
            issued[l] = instruction_i.valid &&
                        (op_latency(instruction_i.op, instruction_i.sew) == simd_lat_t'(l));
        end
    end

    a_one_completion: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(tail_valid_i))
        else $error("Two latency pipes complete in the same cycle");

    a_idle_in_reset: assert property (@(negedge clk_i) !rstn_i |-> !done_instr_i.valid)
        else $error("Completion reported during reset");

    for (genvar g = 1; g <= `SIMD_MAX_LAT; g++) begin : g_lat
        a_exact_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
            $past(issued[g], g) |-> (done_instr_i.valid && (done_lat_i == simd_lat_t'(g))))
            else $error("Instruction of latency %0d did not complete on time", g);
    end

endmodule

bind simd_latency_tracker simd_unit_properties properties_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instruction_i (instruction_i),
    .done_instr_i  (done_instr_o),
    .done_lat_i    (done_lat_o),
    .tail_valid_i  ({tail[5].valid, tail[4].valid, tail[3].valid, tail[2].valid, tail[1].valid})
);

// File: testbench/tb_simd_unit.sv
/*
 * Testbench for the vector SIMD unit
 * Random issue of every op class, checked against a reference model
 * through a queue of results tagged with their completion cycle
 */
`timescale 1ns/100ps
`include "simd_defs.svh"

module tb_simd_unit;

    import simd_pkg::*;

    localparam int N_ALU    = 60;
    localparam int N_MUL    = 24;
    localparam int N_RED    = 24;
    localparam int N_MASK   = 24;
    localparam int N_SCALAR = 16;
    localparam int N_INSTR  = N_ALU + N_MUL + N_RED + N_MASK + N_SCALAR;
    localparam int TIMEOUT_CYCLES = N_INSTR * `SIMD_MAX_LAT + 100;

    localparam int T_ALU    = 0;
    localparam int T_MUL    = 1;
    localparam int T_RED    = 2;
    localparam int T_MASK   = 3;
    localparam int T_SCALAR = 4;

    localparam sew_e     SEWS [4]    = '{SEW_8, SEW_16, SEW_32, SEW_64};
    localparam simd_op_e ALU_OPS [5] = '{VADD, VSUB, VAND, VOR, VXOR};
    localparam simd_op_e RED_OPS [4] = '{VREDSUM, VREDAND, VREDOR, VREDXOR};

    typedef struct packed {
        logic      is_scalar;
        simd_vwb_t vwb;
        simd_swb_t swb;
    } expect_t;

    typedef struct packed {
        logic [31:0] due;       // Cycle in which the result is shown
        expect_t     want;
    } pending_t;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    simd_instr_t instruction;
    simd_swb_t   swb;
    simd_vwb_t   vwb;
    logic [31:0] cycle = '0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    pending_t    pending [$];

    simd_unit simd_unit_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (instruction),
        .swb_o         (swb),
        .vwb_o         (vwb)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    always @(posedge clk_i) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results still pending",
                     cycle, pending.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [63:0] element(logic [127:0] v, int idx, int ew);
        logic [63:0] m;
        m = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        element = 64'(v >> (idx * ew)) & m;
    endfunction

    // vs2 is a, vs1 or the scalar is b
    function automatic logic [63:0] elem_op(simd_op_e op, logic [63:0] a, logic [63:0] b);
        case (op)
            VADD, VREDSUM: elem_op = a + b;
            VSUB:          elem_op = a - b;
            VAND, VREDAND: elem_op = a & b;
            VOR, VREDOR:   elem_op = a | b;
            VXOR, VREDXOR: elem_op = a ^ b;
            VMUL:          elem_op = a * b;
            VMERGE:        elem_op = b;
            default:       elem_op = '0;
        endcase
    endfunction

    function automatic expect_t expected_result(simd_instr_t in);
        expect_t     e;
        int          ew;
        int          n;
        logic [63:0] m;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        e = '0;
        ew = 8 << in.sew;
        n = `SIMD_VLEN / ew;
        m = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        if (in.op == VMV_X_S || in.op == VEXT) begin
            e.is_scalar = 1'b1;
            e.swb.valid = 1'b1;
            e.swb.rd = in.rd;
            if (in.op == VMV_X_S) begin
                r = element(in.data_vs2, 0, ew);
                if (r[ew-1]) r = r | ~m;                    // Sign extension
            end else begin
                r = (in.data_rs1 < 64'(n)) ? element(in.data_vs2, int'(in.data_rs1), ew) : '0;
            end
            e.swb.result = r;
            return e;
        end
        e.vwb.valid = 1'b1;
        e.vwb.vd = in.vd;
        if (is_reduction(in.op)) begin
            r = element(in.data_vs1, 0, ew);
            for (int i = 0; i < n; i++) begin
                r = elem_op(in.op, r, element(in.data_vs2, i, ew)) & m;
            end
            e.vwb.vresult = (in.data_old_vd & ~128'(m)) | 128'(r);
            return e;
        end
        for (int i = 0; i < n; i++) begin
            a = element(in.data_vs2, i, ew);
            if (in.is_opvx) b = in.data_rs1 & m;
            else if (in.is_opvi) b = {{59{in.imm[4]}}, in.imm} & m;
            else b = element(in.data_vs1, i, ew);
            if (!in.use_mask || in.data_vm[i]) r = elem_op(in.op, a, b) & m;
            else if (in.op == VMERGE) r = a;
            else r = element(in.data_old_vd, i, ew);
            e.vwb.vresult = e.vwb.vresult | (128'(r) << (i * ew));
        end
        return e;
    endfunction

    function automatic logic [127:0] rand_vec();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    function automatic simd_instr_t make_instr(simd_op_e op, sew_e sew, int form, logic use_mask);
        simd_instr_t in;
        in = '0;
        in.valid = 1'b1;
        in.op = op;
        in.sew = sew;
        in.use_mask = use_mask;
        in.is_opvx = (form == 1);
        in.is_opvi = (form == 2);
        in.imm = 5'($urandom);
        in.data_rs1 = {$urandom, $urandom};
        in.data_vs1 = rand_vec();
        in.data_vs2 = rand_vec();
        in.data_old_vd = rand_vec();
        in.data_vm = rand_vec();
        in.vd = 5'($urandom);
        in.rd = 5'($urandom);
        return in;
    endfunction

    function automatic simd_instr_t next_instr(int kind, int i);
        simd_instr_t in;
        int          n;
        case (kind)
            T_ALU:  in = make_instr(ALU_OPS[$urandom % 5], SEWS[i % 4], (i / 4) % 3, 1'b0);
            T_MUL:  in = make_instr(VMUL, SEWS[i % 4], int'($urandom % 3), 1'b0);
            T_RED:  in = make_instr(RED_OPS[(i / 4) % 4], SEWS[i % 4], 0, 1'b0);
            T_MASK: in = make_instr((i % 2 == 0) ? ALU_OPS[$urandom % 5] : VMERGE,
                                    SEWS[(i / 2) % 4], int'($urandom % 3), 1'b1);
            default: begin
                in = make_instr((i % 2 == 1) ? VEXT : VMV_X_S, SEWS[(i / 2) % 4], 0, 1'b0);
                n = `SIMD_VLEN / (8 << in.sew);
                if (i % 8 == 1) in.data_rs1 = {$urandom, $urandom} | 64'h1_0000_0000;
                else if (i % 8 == 5) in.data_rs1 = 64'(n) + 64'($urandom % 100);
                else in.data_rs1 = 64'($urandom % n);
            end
        endcase
        return in;
    endfunction

    function automatic logic due_taken(logic [31:0] due);
        foreach (pending[k]) begin
            if (pending[k].due == due) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Holds back an instruction whose completion would meet another one
    task automatic issue(simd_instr_t ins);
        pending_t p;
        @(posedge clk_i);
        p.due = cycle + 1 + op_latency(ins.op, ins.sew);
        while (due_taken(p.due)) begin
            instruction <= '0;
            @(posedge clk_i);
            p.due = cycle + 1 + op_latency(ins.op, ins.sew);
        end
        instruction <= ins;
        p.want = expected_result(ins);
        pending.push_back(p);
    endtask

    task automatic drain();
        @(posedge clk_i);
        instruction <= '0;
        while (pending.size() != 0) @(posedge clk_i);
    endtask

    task automatic run_test(string name, int kind, int count);
        int err0;
        int chk0;
        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < count; i++) issue(next_instr(kind, i));
        drain();
        tests++;
        $display("%-10s %0d results checked, %0d errors", name, checks - chk0, errors - err0);
    endtask

    task automatic idle_test(int n);
        int err0;
        err0 = errors;
        repeat (n) @(posedge clk_i);
        tests++;
        $display("%-10s %0d idle cycles, %0d errors", "idle", n, errors - err0);
    endtask

    task automatic check_vwb(simd_vwb_t got, simd_vwb_t want);
        if (got !== want) begin
            $display("ERROR @%0t: vwb vd %0d = %h, expected vd %0d = %h",
                     $time, got.vd, got.vresult, want.vd, want.vresult);
            errors++;
        end
    endtask

    task automatic check_swb(simd_swb_t got, simd_swb_t want);
        if (got !== want) begin
            $display("ERROR @%0t: swb rd %0d = %h, expected rd %0d = %h",
                     $time, got.rd, got.result, want.rd, want.result);
            errors++;
        end
    endtask

    // Outputs are stable in the middle of the cycle
    always @(negedge clk_i) begin : compare
        int      idx;
        expect_t want;
        idx = -1;
        foreach (pending[k]) begin
            if (pending[k].due == cycle) idx = k;
        end
        if (idx >= 0) begin
            want = pending[idx].want;
            pending.delete(idx);
            checks++;
            if (want.is_scalar) begin
                if (!swb.valid) begin
                    $display("Scalar result missing at cycle %0d", cycle);
                    errors++;
                end else check_swb(swb, want.swb);
                if (vwb.valid) begin
                    $display("Vector write-back shown for a scalar op at cycle %0d", cycle);
                    errors++;
                end
            end else begin
                if (!vwb.valid) begin
                    $display("Vector result missing at cycle %0d", cycle);
                    errors++;
                end else check_vwb(vwb, want.vwb);
                if (swb.valid) begin
                    $display("Scalar write-back shown for a vector op at cycle %0d", cycle);
                    errors++;
                end
            end
        end else if (swb.valid || vwb.valid) begin
            $display("Write-back shown at cycle %0d with no instruction due", cycle);
            errors++;
        end
    end

    initial begin
        void'($urandom(32'hef60));
        rstn_i = 1'b0;
        instruction = '0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        idle_test(20);
        run_test("alu", T_ALU, N_ALU);
        run_test("mul", T_MUL, N_MUL);
        run_test("reduce", T_RED, N_RED);
        run_test("masked", T_MASK, N_MASK);
        run_test("scalar", T_SCALAR, N_SCALAR);
        $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/simd_pkg.sv
rtl/simd_operand_prep.sv
rtl/simd_lane_fu.sv
rtl/simd_latency_tracker.sv
rtl/simd_red_tree.sv
rtl/simd_result_merge.sv
rtl/simd_unit.sv
testbench/simd_unit_properties.sv
testbench/tb_simd_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_simd_unit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
